// File: source/mpmc_pkg.sv
package mpmc_pkg;

	// ==================================================
	// Widths that carry a meaning
	// ==================================================

	// Byte address on the app port of the memory core
	typedef logic [27:0] app_addr_t;

	// One strip is the unit moved by a single app command
	typedef logic [127:0] strip_data_t;

	// Strip count or strip index, a value n stands for n+1 strips
	typedef logic [5:0] strip_cnt_t;

	// Bytes covered by one strip, used for alignment and address stepping
	localparam int STRIP_BYTES = 16;

	// ==================================================
	// Controller states
	// ==================================================

	// Writes pass through WRITE_DATA0..2 and reads through READ_DATA0, READ_DATA1
	// and READ_WAIT before both return to IDLE
	typedef enum logic [2:0] {
		IDLE        = 3'd0,
		WRITE_DATA0 = 3'd1,
		WRITE_DATA1 = 3'd2,
		WRITE_DATA2 = 3'd3,
		READ_DATA0  = 3'd4,
		READ_DATA1  = 3'd5,
		READ_WAIT   = 3'd6
	} mpmc_state_t;

	// ==================================================
	// Request and command records
	// ==================================================

	// Request as the host presents it together with the req strobe
	typedef struct packed {
		logic        we;
		app_addr_t   adr;
		strip_cnt_t  num_strips;
		strip_data_t wdata;
	} host_req_t;

	// Checked command handed from decode to the execute stage
	// The address is strip aligned and a write always covers a single strip
	typedef struct packed {
		logic        we;
		app_addr_t   adr;
		strip_cnt_t  num_strips;
		strip_data_t wdata;
	} mpmc_cmd_t;

endpackage

// File: source/mpmc_app_en_gen.sv
module mpmc_app_en_gen (
	input  logic                 clk,
	input  logic                 rst,
	input  mpmc_pkg::mpmc_state_t state,
	input  logic                 rdy,
	input  mpmc_pkg::strip_cnt_t strip_cnt,
	input  mpmc_pkg::strip_cnt_t num_strips,
	output logic                 en
);
	import mpmc_pkg::*;

	logic en_q;
	logic issue_state;

	// The core only latches a command on a cycle where app_rdy is high,
	// so the enable stays up and the command is retried until then
	always_ff @(posedge clk) begin
		if (rst) begin
			en_q <= 1'b0;
		end else begin
			case (state)
				WRITE_DATA1:
					en_q <= 1'b1;
				WRITE_DATA2:
					if (rdy)
						en_q <= 1'b0;
				READ_DATA0:
					en_q <= 1'b1;
				// Keep issuing until the last strip has been taken
				READ_DATA1:
					en_q <= !(rdy && strip_cnt == num_strips);
				default:
					en_q <= 1'b0;
			endcase
		end
	end

	// Only these two states put commands on the app port
	assign issue_state = (state == WRITE_DATA2) || (state == READ_DATA1);

	// The register drops on the edge that closes the accepting cycle,
	// the state mask keeps a stray command off the port on any other state
	assign en = en_q && issue_state;

	// The register is already clear whenever the FSM sits outside the issuing states
	assert property (@(posedge clk) disable iff (rst) !issue_state |-> !en_q);

endmodule

// File: source/mpmc_req_decode.sv
module mpmc_req_decode #(
	parameter int unsigned MEM_STRIPS = 2**20
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                req,
	input  mpmc_pkg::host_req_t req_in,
	input  logic                cmd_take,
	output mpmc_pkg::mpmc_cmd_t cmd,
	output logic                cmd_valid,
	output logic                err
);
	import mpmc_pkg::*;

	// Address bits that select a byte inside one strip
	localparam int OFS_BITS = $clog2(STRIP_BYTES);

	// Strip index with one spare bit, so the end of a long read cannot wrap
	localparam int IDX_W = $bits(app_addr_t) - OFS_BITS + 1;

	app_addr_t        adr_aligned;
	logic [IDX_W-1:0] last_strip;
	logic             out_of_range;

	// ==================================================
	// Request check
	// ==================================================

	always_comb begin
		// Byte offset bits inside a strip are simply dropped
		adr_aligned = req_in.adr & ~app_addr_t'(STRIP_BYTES - 1);
		// Index of the last strip that the request would touch
		last_strip = IDX_W'(req_in.adr >> OFS_BITS) + IDX_W'(req_in.num_strips);
		// Only reads can run past the end, a write covers one strip
		out_of_range = !req_in.we && (last_strip >= IDX_W'(MEM_STRIPS));
	end

	// ==================================================
	// Pending command
	// ==================================================

	// Both err and cmd_valid come up one cycle after the req strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			cmd_valid <= 1'b0;
			err <= 1'b0;
		end else begin
			err <= req && out_of_range;
			if (req && !out_of_range)
				cmd_valid <= 1'b1;
			else if (cmd_take)
				cmd_valid <= 1'b0;
		end
	end

	// The command fields stay put until the next request, which the host
	// cannot give before busy drops
	always_ff @(posedge clk) begin
		if (req) begin
			cmd.we <= req_in.we;
			cmd.adr <= adr_aligned;
			cmd.num_strips <= req_in.we ? '0 : req_in.num_strips;
			cmd.wdata <= req_in.wdata;
		end
	end

	// The host keeps to busy, and busy covers the whole time a command is pending
	assert property (@(posedge clk) disable iff (rst) req |-> !cmd_valid);

endmodule

// File: source/mpmc_state_machine.sv
module mpmc_state_machine (
	input  logic                  clk,
	input  logic                  rst,
	input  mpmc_pkg::mpmc_cmd_t   cmd,
	input  logic                  cmd_valid,
	input  logic                  app_rdy,
	input  logic                  app_wdf_rdy,
	input  logic                  rd_last,
	output logic                  cmd_take,
	output logic                  app_en,
	output logic [2:0]            app_cmd,
	output mpmc_pkg::app_addr_t   app_addr,
	output logic                  app_wdf_wren,
	output mpmc_pkg::strip_data_t app_wdf_data,
	output logic                  app_wdf_end,
	output logic                  start_rd,
	output mpmc_pkg::strip_cnt_t  rd_len,
	output logic                  wr_ack,
	output logic                  busy
);
	import mpmc_pkg::*;

	// Command codes of the app port
	localparam logic [2:0] APP_CMD_WR = 3'b000;
	localparam logic [2:0] APP_CMD_RD = 3'b001;

	mpmc_state_t state;
	strip_cnt_t  strip_cnt;
	strip_cnt_t  num_strips;
	logic        we;
	logic        accept;
	logic        last_rd;
	logic        wr_tail;

	// A command goes to the core on any cycle with app_en and app_rdy both high
	assign accept = app_en && app_rdy;
	// The strip now on the app port is the final one of the read
	assign last_rd = strip_cnt == num_strips;

	assign cmd_take = (state == IDLE) && cmd_valid;
	assign app_cmd = we ? APP_CMD_WR : APP_CMD_RD;
	// Write data goes out as a single beat ahead of the command
	assign app_wdf_wren = state == WRITE_DATA0;
	assign app_wdf_end = state == WRITE_DATA0;
	assign start_rd = state == READ_DATA0;
	assign rd_len = num_strips;
	assign wr_ack = (state == WRITE_DATA2) && accept;

	// The pending command and the cycle of wr_done count as busy as well
	assign busy = cmd_valid || (state != IDLE) || wr_tail;

	// ==================================================
	// Command FSM
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			strip_cnt <= '0;
			wr_tail <= 1'b0;
		end else begin
			wr_tail <= wr_ack;
			case (state)
				IDLE: begin
					strip_cnt <= '0;
					if (cmd_valid)
						state <= cmd.we ? WRITE_DATA0 : READ_DATA0;
				end
				// Hold the write beat until the data FIFO takes it
				WRITE_DATA0:
					if (app_wdf_rdy)
						state <= WRITE_DATA1;
				WRITE_DATA1:
					state <= WRITE_DATA2;
				WRITE_DATA2:
					if (accept)
						state <= IDLE;
				READ_DATA0:
					state <= READ_DATA1;
				// One strip per accepted command
				READ_DATA1:
					if (accept) begin
						strip_cnt <= strip_cnt + 1'b1;
						if (last_rd)
							state <= READ_WAIT;
					end
				READ_WAIT:
					if (rd_last)
						state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	// Command fields are taken over on leaving IDLE, the read address
	// then steps by one strip for every accepted command
	always_ff @(posedge clk) begin
		if (cmd_take) begin
			we <= cmd.we;
			num_strips <= cmd.num_strips;
			app_addr <= cmd.adr;
			app_wdf_data <= cmd.wdata;
		end else if (state == READ_DATA1 && accept) begin
			app_addr <= app_addr + app_addr_t'(STRIP_BYTES);
		end
	end

	mpmc_app_en_gen u_app_en_gen (
		.clk        (clk),
		.rst        (rst),
		.state      (state),
		.rdy        (app_rdy),
		.strip_cnt  (strip_cnt),
		.num_strips (num_strips),
		.en         (app_en)
	);

	assert property (@(posedge clk) disable iff (rst)
		state inside {IDLE, WRITE_DATA0, WRITE_DATA1, WRITE_DATA2,
			READ_DATA0, READ_DATA1, READ_WAIT});

endmodule

// File: source/mpmc_read_collect.sv
module mpmc_read_collect (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start_rd,
	input  mpmc_pkg::strip_cnt_t  rd_len,
	input  logic                  wr_ack,
	input  mpmc_pkg::strip_data_t app_rd_data,
	input  logic                  app_rd_data_valid,
	output logic                  rd_valid,
	output mpmc_pkg::strip_data_t rd_data,
	output logic                  rd_done,
	output logic                  rd_last,
	output logic                  wr_done
);
	import mpmc_pkg::*;

	// Strips still to come, minus one, as in the command
	strip_cnt_t remain;
	// A read has been started and its last strip is not back yet
	logic       active;

	// ==================================================
	// Completion tracking
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			remain <= '0;
			active <= 1'b0;
			rd_valid <= 1'b0;
			rd_done <= 1'b0;
			wr_done <= 1'b0;
		end else begin
			// A write is complete as soon as its command is accepted
			wr_done <= wr_ack;
			rd_valid <= app_rd_data_valid;
			rd_done <= 1'b0;
			if (start_rd) begin
				remain <= rd_len;
				active <= 1'b1;
			end else if (app_rd_data_valid) begin
				if (remain == '0) begin
					// The final strip goes out together with rd_done
					rd_done <= 1'b1;
					active <= 1'b0;
				end else begin
					remain <= remain - 1'b1;
				end
			end
		end
	end

	// Returned strips arrive in address order, one per valid cycle
	always_ff @(posedge clk) begin
		if (app_rd_data_valid)
			rd_data <= app_rd_data;
	end

	// The FSM leaves READ_WAIT on the same pulse the host sees
	assign rd_last = rd_done;

	// Data only come back for commands issued after start_rd
	assert property (@(posedge clk) disable iff (rst) app_rd_data_valid |-> active);

endmodule

// File: source/mpmc_top.sv
module mpmc_top #(
	parameter int unsigned MEM_STRIPS = 2**20
) (
	input  logic                  clk,
	input  logic                  rst,
	// Host side
	input  logic                  req,
	input  mpmc_pkg::host_req_t   req_in,
	output logic                  busy,
	output logic                  err,
	output logic                  rd_valid,
	output mpmc_pkg::strip_data_t rd_data,
	output logic                  rd_done,
	output logic                  wr_done,
	// App port of the memory core
	output logic                  app_en,
	output logic [2:0]            app_cmd,
	output mpmc_pkg::app_addr_t   app_addr,
	output logic                  app_wdf_wren,
	output mpmc_pkg::strip_data_t app_wdf_data,
	output logic                  app_wdf_end,
	input  logic                  app_rdy,
	input  logic                  app_wdf_rdy,
	input  mpmc_pkg::strip_data_t app_rd_data,
	input  logic                  app_rd_data_valid
);
	import mpmc_pkg::*;

	// ==================================================
	// Stage links
	// ==================================================

	mpmc_cmd_t  cmd;
	logic       cmd_valid;
	logic       cmd_take;
	logic       start_rd;
	strip_cnt_t rd_len;
	logic       wr_ack;
	logic       rd_last;

	mpmc_req_decode #(
		.MEM_STRIPS (MEM_STRIPS)
	) u_decode (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.req_in    (req_in),
		.cmd_take  (cmd_take),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.err       (err)
	);

	mpmc_state_machine u_exec (
		.clk          (clk),
		.rst          (rst),
		.cmd          (cmd),
		.cmd_valid    (cmd_valid),
		.app_rdy      (app_rdy),
		.app_wdf_rdy  (app_wdf_rdy),
		.rd_last      (rd_last),
		.cmd_take     (cmd_take),
		.app_en       (app_en),
		.app_cmd      (app_cmd),
		.app_addr     (app_addr),
		.app_wdf_wren (app_wdf_wren),
		.app_wdf_data (app_wdf_data),
		.app_wdf_end  (app_wdf_end),
		.start_rd     (start_rd),
		.rd_len       (rd_len),
		.wr_ack       (wr_ack),
		.busy         (busy)
	);

	// Result stage for both reads and writes
	mpmc_read_collect u_result (
		.clk               (clk),
		.rst               (rst),
		.start_rd          (start_rd),
		.rd_len            (rd_len),
		.wr_ack            (wr_ack),
		.app_rd_data       (app_rd_data),
		.app_rd_data_valid (app_rd_data_valid),
		.rd_valid          (rd_valid),
		.rd_data           (rd_data),
		.rd_done           (rd_done),
		.rd_last           (rd_last),
		.wr_done           (wr_done)
	);

endmodule

// File: tb/mpmc_mem_model.sv
module mpmc_mem_model #(
	parameter int          RD_LAT = 4,
	parameter logic [31:0] SEED   = 32'd89547
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  app_en,
	input  logic [2:0]            app_cmd,
	input  mpmc_pkg::app_addr_t   app_addr,
	input  logic                  app_wdf_wren,
	input  mpmc_pkg::strip_data_t app_wdf_data,
	input  logic                  app_wdf_end,
	output logic                  app_rdy,
	output logic                  app_wdf_rdy,
	output mpmc_pkg::strip_data_t app_rd_data,
	output logic                  app_rd_data_valid,
	output int                    rd_cmds,
	output int                    wr_cmds
);
	import mpmc_pkg::*;

	// Storage keyed by the full byte address that the controller presents
	strip_data_t mem [app_addr_t];
	// Write beats wait here until their command comes along
	strip_data_t wdf_q [$];
	logic [31:0] lfsr;
	logic        pipe_v [RD_LAT];
	strip_data_t pipe_d [RD_LAT];

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	initial begin
		lfsr = SEED;
		app_rdy = 1'b0;
		app_wdf_rdy = 1'b0;
		app_rd_data = '0;
		app_rd_data_valid = 1'b0;
		rd_cmds = 0;
		wr_cmds = 0;
	end

	// ==================================================
	// Ready levels and read return, on the falling edge
	// ==================================================

	// Ready levels stay low until reset has been seen low
	always @(negedge clk) begin
		if (rst !== 1'b0) begin
			app_rdy = 1'b0;
			app_wdf_rdy = 1'b0;
			app_rd_data_valid = 1'b0;
		end else begin
			// One LFSR bit for each ready level
			app_rdy = lfsr[0];
			lfsr = lfsr_next(lfsr);
			app_wdf_rdy = lfsr[0];
			lfsr = lfsr_next(lfsr);
			app_rd_data_valid = pipe_v[RD_LAT-1];
			app_rd_data = pipe_d[RD_LAT-1];
		end
	end

	// ==================================================
	// Command and data acceptance
	// ==================================================

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < RD_LAT; i++)
				pipe_v[i] <= 1'b0;
			rd_cmds = 0;
			wr_cmds = 0;
		end else begin
			// The read pipe is RD_LAT deep, counting the output stage
			for (int i = RD_LAT - 1; i > 0; i--) begin
				pipe_v[i] <= pipe_v[i-1];
				pipe_d[i] <= pipe_d[i-1];
			end
			pipe_v[0] <= 1'b0;
			// A write beat is only complete once app_wdf_end marks it as the last one
			if (app_wdf_wren && app_wdf_rdy && app_wdf_end)
				wdf_q.push_back(app_wdf_data);
			if (app_en && app_rdy) begin
				if (app_cmd == 3'b000) begin
					wr_cmds++;
					if (wdf_q.size() != 0)
						mem[app_addr] = wdf_q.pop_front();
				end else begin
					rd_cmds++;
					pipe_v[0] <= 1'b1;
					// Unwritten strips read back a pattern of their own address
					pipe_d[0] <= mem.exists(app_addr) ? mem[app_addr] : {4{4'hA, app_addr}};
				end
			end
		end
	end

endmodule

// File: tb/mpmc_tb.sv
module mpmc_tb;
	import mpmc_pkg::*;

	localparam int unsigned MEM_STRIPS = 256;
	localparam int          RD_LAT = 5;
	localparam int          TIMEOUT = 3000;

	// Snapshot of the event counters around one request
	typedef struct packed {
		int rv;
		int rdn;
		int wd;
		int en;
		int acc;
		int wc;
	} counts_t;

	logic        clk;
	logic        rst;
	logic        req;
	host_req_t   req_in;
	logic        busy;
	logic        err;
	logic        rd_valid;
	strip_data_t rd_data;
	logic        rd_done;
	logic        wr_done;
	logic        app_en;
	logic [2:0]  app_cmd;
	app_addr_t   app_addr;
	logic        app_wdf_wren;
	strip_data_t app_wdf_data;
	logic        app_wdf_end;
	logic        app_rdy;
	logic        app_wdf_rdy;
	strip_data_t app_rd_data;
	logic        app_rd_data_valid;
	int          rd_cmds;
	int          wr_cmds;

	logic [31:0] lfsr;
	// Shadow memory keyed by strip index
	strip_data_t shadow [int];
	strip_data_t exp_q [$];
	int          errors = 0;
	int          checks = 0;
	int          failed_tests = 0;
	int          rd_valid_cnt = 0;
	int          rd_done_cnt = 0;
	int          wr_done_cnt = 0;
	int          app_en_cnt = 0;

	mpmc_top #(
		.MEM_STRIPS (MEM_STRIPS)
	) dut (
		.clk (clk), .rst (rst), .req (req), .req_in (req_in),
		.busy (busy), .err (err), .rd_valid (rd_valid), .rd_data (rd_data),
		.rd_done (rd_done), .wr_done (wr_done),
		.app_en (app_en), .app_cmd (app_cmd), .app_addr (app_addr),
		.app_wdf_wren (app_wdf_wren), .app_wdf_data (app_wdf_data),
		.app_wdf_end (app_wdf_end), .app_rdy (app_rdy), .app_wdf_rdy (app_wdf_rdy),
		.app_rd_data (app_rd_data), .app_rd_data_valid (app_rd_data_valid)
	);

	mpmc_mem_model #(
		.RD_LAT (RD_LAT),
		.SEED   (32'd89547)
	) u_mem (
		.clk (clk), .rst (rst), .app_en (app_en), .app_cmd (app_cmd),
		.app_addr (app_addr), .app_wdf_wren (app_wdf_wren),
		.app_wdf_data (app_wdf_data), .app_wdf_end (app_wdf_end),
		.app_rdy (app_rdy), .app_wdf_rdy (app_wdf_rdy), .app_rd_data (app_rd_data),
		.app_rd_data_valid (app_rd_data_valid), .rd_cmds (rd_cmds), .wr_cmds (wr_cmds)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ==================================================
	// Random numbers and reference model
	// ==================================================

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	// One LFSR step for every bit handed out
	function automatic logic [127:0] rand_bits(input int n);
		logic [127:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[126:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return r;
	endfunction

	// Strip k of a read from base, where the byte offset inside a strip does not count
	function automatic strip_data_t expected_strip(input app_addr_t base, input int k);
		int idx;
		idx = int'(base / STRIP_BYTES) + k;
		if (shadow.exists(idx))
			return shadow[idx];
		return {4{4'hA, app_addr_t'(idx * STRIP_BYTES)}};
	endfunction

	// ==================================================
	// Compare tasks
	// ==================================================

	task automatic check_strip(input string name, input strip_data_t got, input strip_data_t want);
		checks++;
		if (got !== want) begin
			$display("ERROR %0t %s: got %h, expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input strip_cnt_t got, input strip_cnt_t want);
		checks++;
		if (got !== want) begin
			$display("ERROR %0t %s: got %0d, expected %0d", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		checks++;
		if (got !== want) begin
			$display("ERROR %0t %s: got %b, expected %b", $time, name, got, want);
			errors++;
		end
	endtask

	// Host outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		strip_data_t want;
		if (!rst) begin
			if (app_en)
				app_en_cnt++;
			if (wr_done)
				wr_done_cnt++;
			if (rd_done && !rd_valid) begin
				$display("ERROR at %0t: rd_done came without a strip", $time);
				errors++;
			end
			if (rd_valid) begin
				rd_valid_cnt++;
				if (rd_done)
					rd_done_cnt++;
				if (exp_q.size() == 0) begin
					$display("ERROR at %0t: a strip came back that no read asked for", $time);
					errors++;
				end else begin
					want = exp_q.pop_front();
					check_strip("rd_data", rd_data, want);
					// rd_done belongs to the last strip and to no other
					check_flag("rd_done", rd_done, exp_q.size() == 0);
				end
			end
		end
	end

	// ==================================================
	// Host side tasks
	// ==================================================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(negedge clk);
		while (busy) begin
			if (n == TIMEOUT)
				abort_run($sformatf("Timeout at %0t, busy never dropped", $time));
			@(negedge clk);
			n++;
		end
	endtask

	// Monitor counters are read on the rising edge, the model's on the falling edge
	task automatic take_counts(output counts_t c);
		@(posedge clk);
		c.rv = rd_valid_cnt;
		c.rdn = rd_done_cnt;
		c.wd = wr_done_cnt;
		c.en = app_en_cnt;
		@(negedge clk);
		c.acc = rd_cmds;
		c.wc = wr_cmds;
	endtask

	// err must show exactly one cycle after the req strobe, or not at all
	task automatic send_req(input logic we, input app_addr_t adr, input strip_cnt_t n,
			input strip_data_t d, input logic expect_err);
		wait_idle();
		req = 1'b1;
		req_in.we = we;
		req_in.adr = adr;
		req_in.num_strips = n;
		req_in.wdata = d;
		@(negedge clk);
		req = 1'b0;
		check_flag("err", err, expect_err);
	endtask

	task automatic write_strip(input app_addr_t adr, input strip_data_t d);
		shadow[int'(adr / STRIP_BYTES)] = d;
		send_req(1'b1, adr, '0, d, 1'b0);
		wait_idle();
	endtask

	task automatic read_strips(input app_addr_t adr, input strip_cnt_t n);
		for (int k = 0; k <= int'(n); k++)
			exp_q.push_back(expected_strip(adr, k));
		send_req(1'b0, adr, n, '0, 1'b0);
		wait_idle();
	endtask

	task automatic end_test(input string name, input int err0);
		if (errors == err0) begin
			$display("[%s] ok", name);
		end else begin
			$display("[%s] %0d errors", name, errors - err0);
			failed_tests++;
		end
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		counts_t     c0;
		counts_t     c1;
		app_addr_t   adr;
		strip_data_t d;
		strip_cnt_t  n;
		strip_cnt_t  m;
		int          base;
		int          e0;
		lfsr = 32'd89547;
		rst = 1'b1;
		req = 1'b0;
		req_in = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Nothing may move while the host stays quiet
		e0 = errors;
		repeat (20) begin
			@(negedge clk);
			check_flag("busy", busy, 1'b0);
			check_flag("app_en", app_en, 1'b0);
			check_flag("app_wdf_wren", app_wdf_wren, 1'b0);
			check_flag("rd_valid", rd_valid, 1'b0);
			check_flag("rd_done", rd_done, 1'b0);
			check_flag("wr_done", wr_done, 1'b0);
		end
		end_test("idle after reset", e0);

		e0 = errors;
		adr = app_addr_t'(rand_bits(7) * STRIP_BYTES);
		d = rand_bits(128);
		take_counts(c0);
		write_strip(adr, d);
		read_strips(adr, '0);
		take_counts(c1);
		check_count("wr_done pulses", strip_cnt_t'(c1.wd - c0.wd), 1);
		check_count("accepted write commands", strip_cnt_t'(c1.wc - c0.wc), 1);
		check_count("rd_valid pulses", strip_cnt_t'(c1.rv - c0.rv), 1);
		check_count("rd_done pulses", strip_cnt_t'(c1.rdn - c0.rdn), 1);
		check_flag("all strips returned", exp_q.size() == 0, 1'b1);
		end_test("write then single read", e0);

		// Block in the upper half, so base plus length stays below MEM_STRIPS
		e0 = errors;
		base = 128 + int'(rand_bits(6));
		n = strip_cnt_t'(rand_bits(6));
		for (int k = 0; k <= int'(n); k++)
			write_strip(app_addr_t'((base + k) * STRIP_BYTES), rand_bits(128));
		take_counts(c0);
		read_strips(app_addr_t'(base * STRIP_BYTES), n);
		take_counts(c1);
		check_count("rd_valid pulses", strip_cnt_t'(c1.rv - c0.rv - 1), n);
		check_count("rd_done pulses", strip_cnt_t'(c1.rdn - c0.rdn), 1);
		check_flag("all strips returned", exp_q.size() == 0, 1'b1);
		end_test("multi strip read", e0);

		e0 = errors;
		m = strip_cnt_t'(rand_bits(6));
		if (m > n)
			m = n;
		take_counts(c0);
		read_strips(app_addr_t'(base * STRIP_BYTES), m);
		take_counts(c1);
		check_count("accepted read commands", strip_cnt_t'(c1.acc - c0.acc - 1), m);
		check_count("rd_valid pulses", strip_cnt_t'(c1.rv - c0.rv - 1), m);
		check_flag("all strips returned", exp_q.size() == 0, 1'b1);
		end_test("read under back-pressure", e0);

		// Low address bits are set on both the write and the read
		e0 = errors;
		base = int'(rand_bits(7));
		adr = app_addr_t'(base * STRIP_BYTES) | app_addr_t'(rand_bits(4) | 1);
		d = rand_bits(128);
		write_strip(adr, d);
		take_counts(c0);
		read_strips(app_addr_t'(base * STRIP_BYTES) | app_addr_t'(rand_bits(4) | 2), '0);
		take_counts(c1);
		check_count("rd_valid pulses", strip_cnt_t'(c1.rv - c0.rv), 1);
		check_flag("all strips returned", exp_q.size() == 0, 1'b1);
		end_test("unaligned address", e0);

		e0 = errors;
		n = strip_cnt_t'(6 + rand_bits(5));
		take_counts(c0);
		send_req(1'b0, app_addr_t'(250 * STRIP_BYTES), n, '0,
			(250 + int'(n)) >= int'(MEM_STRIPS));
		wait_idle();
		repeat (8) begin
			@(negedge clk);
			check_flag("app_en", app_en, 1'b0);
		end
		take_counts(c1);
		check_count("app_en cycles", strip_cnt_t'(c1.en - c0.en), 0);
		check_flag("busy", busy, 1'b0);
		end_test("read past end of memory", e0);

		$display("tests run: 6, failed: %0d, checks: %0d, errors: %0d",
			failed_tests, checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: filelist.f
source/mpmc_pkg.sv
source/mpmc_app_en_gen.sv
source/mpmc_req_decode.sv
source/mpmc_state_machine.sv
source/mpmc_read_collect.sv
source/mpmc_top.sv
tb/mpmc_mem_model.sv
tb/mpmc_tb.sv

// File: Bender.yml
package:
  name: mpmc

sources:
  - source/mpmc_pkg.sv
  - source/mpmc_app_en_gen.sv
  - source/mpmc_req_decode.sv
  - source/mpmc_state_machine.sv
  - source/mpmc_read_collect.sv
  - source/mpmc_top.sv
  - target: test
    files:
      - tb/mpmc_mem_model.sv
      - tb/mpmc_tb.sv
